// File: design/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// first fetch address out of reset
`define RESET_PC    32'h1c00_0000

// 3R-type ops in inst[31:15]
`define OP_ADD_W    17'h00020
`define OP_SUB_W    17'h00022
`define OP_SLT      17'h00024
`define OP_SLTU     17'h00025
`define OP_AND      17'h00029
`define OP_OR       17'h0002a
`define OP_XOR      17'h0002b

// 2RI12-type opcode in inst[31:22]
`define OP_ADDI_W   10'h00a

// 1RI20-type opcode in inst[31:25]
`define OP_LU12I_W  7'h0a

// branch opcodes in inst[31:26]
`define OP_B        6'h14
`define OP_BEQ      6'h16
`define OP_BNE      6'h17

`endif

// File: design/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // raw immediate fields as they sit in the instruction
    typedef logic [11:0] si12_t;
    typedef logic [19:0] si20_t;
    typedef logic [15:0] off16_t;
    typedef logic [25:0] off26_t;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_xor  = 4'd6,
        // src2 passed straight through for lu12i.w
        alu_pass = 4'd7
    } alu_op_e;

    // decode -> execute
    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_e   alu_op;
        word_t     src1;
        word_t     src2;
        logic      gr_we;
        reg_addr_t dest;
    } id_ex_t;

    // execute -> writeback
    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      gr_we;
        reg_addr_t dest;
        word_t     result;
    } ex_wb_t;

    // forwarded result back into decode
    typedef struct packed {
        logic      we;
        reg_addr_t dest;
        word_t     value;
    } bypass_t;

endpackage

// File: design/fetch_stage.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module fetch_stage import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  br_taken,
    input  word_t br_target,
    output logic  inst_req,
    output word_t inst_addr,
    output word_t id_pc,
    output logic  id_valid
);

    word_t pc;
    word_t next_pc;

    // a taken branch in decode redirects the very next fetch
    assign next_pc = br_taken ? br_target : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= `RESET_PC;
            inst_req <= 1'b0;
        end else begin
            inst_req <= 1'b1;
            if (inst_req) begin
                pc <= next_pc;
            end
        end
    end

    assign inst_addr = pc;

    // word for this pc returns next cycle, so pc follows it
    always_ff @(posedge clk) begin
        id_pc <= pc;
    end

    // slot fetched alongside a taken branch is dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= inst_req & ~br_taken;
        end
    end

endmodule

// File: design/decode_stage.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module decode_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  word_t     inst,
    input  word_t     id_pc,
    input  logic      id_valid,
    output reg_addr_t rf_raddr1,
    output reg_addr_t rf_raddr2,
    input  word_t     rf_rdata1,
    input  word_t     rf_rdata2,
    input  bypass_t   ex_bypass,
    input  bypass_t   wb_bypass,
    output logic      br_taken,
    output word_t     br_target,
    output id_ex_t    id_ex
);

    reg_addr_t rd;
    reg_addr_t rj;
    reg_addr_t rk;
    si12_t     si12;
    si20_t     si20;
    off16_t    offs16;
    off26_t    offs26;

    logic      is_rr_op;
    logic      is_addi_w;
    logic      is_lu12i_w;
    logic      is_beq;
    logic      is_bne;
    logic      is_b;
    alu_op_e   rr_alu_op;

    alu_op_e   alu_op;
    logic      gr_we;
    logic      src2_is_imm;
    word_t     imm;
    word_t     br_offset;

    word_t     rj_value;
    word_t     rkd_value;
    logic      operands_equal;
    id_ex_t    id_ex_next;

    // execute bypass first, then writeback bypass, then rf data
    function automatic word_t fwd_operand(
        input reg_addr_t addr,
        input word_t     rf_data,
        input bypass_t   ex_bp,
        input bypass_t   wb_bp
    );
        word_t value;
        if (addr == 5'd0) begin
            value = '0;
        end else if (ex_bp.we && ex_bp.dest == addr) begin
            value = ex_bp.value;
        end else if (wb_bp.we && wb_bp.dest == addr) begin
            value = wb_bp.value;
        end else begin
            value = rf_data;
        end
        return value;
    endfunction

    // instruction fields
    assign rd     = inst[4:0];
    assign rj     = inst[9:5];
    assign rk     = inst[14:10];
    assign si12   = inst[21:10];
    assign si20   = inst[24:5];
    assign offs16 = inst[25:10];
    assign offs26 = {inst[9:0], inst[25:10]};

    // 3R ops share one opcode field
    always_comb begin
        is_rr_op  = 1'b1;
        rr_alu_op = alu_add;
        case (inst[31:15])
            `OP_ADD_W: rr_alu_op = alu_add;
            `OP_SUB_W: rr_alu_op = alu_sub;
            `OP_SLT:   rr_alu_op = alu_slt;
            `OP_SLTU:  rr_alu_op = alu_sltu;
            `OP_AND:   rr_alu_op = alu_and;
            `OP_OR:    rr_alu_op = alu_or;
            `OP_XOR:   rr_alu_op = alu_xor;
            default:   is_rr_op  = 1'b0;
        endcase
    end

    assign is_addi_w  = inst[31:22] == `OP_ADDI_W;
    assign is_lu12i_w = inst[31:25] == `OP_LU12I_W;
    assign is_beq     = inst[31:26] == `OP_BEQ;
    assign is_bne     = inst[31:26] == `OP_BNE;
    assign is_b       = inst[31:26] == `OP_B;

    always_comb begin
        if (is_lu12i_w) begin
            alu_op = alu_pass;
        end else if (is_rr_op) begin
            alu_op = rr_alu_op;
        end else begin
            alu_op = alu_add;
        end
    end

    // writes to r0 are dropped here and nowhere else
    assign gr_we       = (is_rr_op | is_addi_w | is_lu12i_w) && rd != 5'd0;
    assign src2_is_imm = is_addi_w | is_lu12i_w;
    assign imm         = is_lu12i_w ? {si20, 12'b0} : {{20{si12[11]}}, si12};

    // beq/bne compare rj against rd
    assign rf_raddr1 = rj;
    assign rf_raddr2 = (is_beq | is_bne) ? rd : rk;

    assign rj_value  = fwd_operand(rj, rf_rdata1, ex_bypass, wb_bypass);
    assign rkd_value = fwd_operand(rf_raddr2, rf_rdata2, ex_bypass, wb_bypass);

    // branch resolution
    assign operands_equal = rj_value == rkd_value;
    assign br_taken = id_valid &
                      (is_b | (is_beq & operands_equal) | (is_bne & ~operands_equal));
    assign br_offset = is_b ? {{4{offs26[25]}}, offs26, 2'b00}
                            : {{14{offs16[15]}}, offs16, 2'b00};
    assign br_target = id_pc + br_offset;

    assign id_ex_next = '{
        valid:  id_valid,
        pc:     id_pc,
        alu_op: alu_op,
        src1:   rj_value,
        src2:   src2_is_imm ? imm : rkd_value,
        gr_we:  gr_we,
        dest:   rd
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex <= id_ex_next;
        end
    end

endmodule

// File: design/execute_stage.sv
`timescale 1ns/100ps

module execute_stage import cpu_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  id_ex_t  id_ex,
    output bypass_t ex_bypass,
    output ex_wb_t  ex_wb
);

    word_t alu_result;

    always_comb begin
        case (id_ex.alu_op)
            alu_add:  alu_result = id_ex.src1 + id_ex.src2;
            alu_sub:  alu_result = id_ex.src1 - id_ex.src2;
            alu_slt:  alu_result = {31'b0, $signed(id_ex.src1) < $signed(id_ex.src2)};
            alu_sltu: alu_result = {31'b0, id_ex.src1 < id_ex.src2};
            alu_and:  alu_result = id_ex.src1 & id_ex.src2;
            alu_or:   alu_result = id_ex.src1 | id_ex.src2;
            alu_xor:  alu_result = id_ex.src1 ^ id_ex.src2;
            alu_pass: alu_result = id_ex.src2;
            default:  alu_result = id_ex.src1 + id_ex.src2;
        endcase
    end

    // result goes back to decode in the same cycle, so no stall on
    // back-to-back dependences
    assign ex_bypass = '{
        we:    id_ex.valid & id_ex.gr_we,
        dest:  id_ex.dest,
        value: alu_result
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_wb.valid <= 1'b0;
        end else begin
            ex_wb <= '{
                valid:  id_ex.valid,
                pc:     id_ex.pc,
                gr_we:  id_ex.gr_we,
                dest:   id_ex.dest,
                result: alu_result
            };
        end
    end

endmodule

// File: design/regfile.sv
`timescale 1ns/100ps

module regfile import cpu_pkg::*; (
    input  logic      clk,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata
);

    word_t rf [32];

    always_ff @(posedge clk) begin
        if (we) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 reads zero and a same-cycle write passes through
    assign rdata1 = (raddr1 == 5'd0) ? '0 :
                    (we && waddr == raddr1) ? wdata : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 :
                    (we && waddr == raddr2) ? wdata : rf[raddr2];

endmodule

// File: design/cpu_core_top.sv
`timescale 1ns/100ps

module cpu_core_top import cpu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    output logic       inst_req,
    output word_t      inst_addr,
    input  word_t      inst_rdata,
    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_we,
    output reg_addr_t  debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    logic      br_taken;
    word_t     br_target;
    word_t     id_pc;
    logic      id_valid;

    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    id_ex_t    id_ex;
    ex_wb_t    ex_wb;
    bypass_t   ex_bypass;
    bypass_t   wb_bypass;

    fetch_stage u_fetch (
        .clk       (clk),
        .reset     (reset),
        .br_taken  (br_taken),
        .br_target (br_target),
        .inst_req  (inst_req),
        .inst_addr (inst_addr),
        .id_pc     (id_pc),
        .id_valid  (id_valid)
    );

    decode_stage u_decode (
        .clk       (clk),
        .reset     (reset),
        .inst      (inst_rdata),
        .id_pc     (id_pc),
        .id_valid  (id_valid),
        .rf_raddr1 (rf_raddr1),
        .rf_raddr2 (rf_raddr2),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .ex_bypass (ex_bypass),
        .wb_bypass (wb_bypass),
        .br_taken  (br_taken),
        .br_target (br_target),
        .id_ex     (id_ex)
    );

    execute_stage u_execute (
        .clk       (clk),
        .reset     (reset),
        .id_ex     (id_ex),
        .ex_bypass (ex_bypass),
        .ex_wb     (ex_wb)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    // writeback
    assign rf_we    = ex_wb.valid & ex_wb.gr_we;
    assign rf_waddr = ex_wb.dest;
    assign rf_wdata = ex_wb.result;

    assign wb_bypass = '{
        we:    rf_we,
        dest:  rf_waddr,
        value: rf_wdata
    };

    // trace port
    assign debug_wb_pc       = ex_wb.pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

// File: verif/clk_gen.sv
`timescale 1ns/100ps

module clk_gen #(
    parameter int CLK_PERIOD   = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // released just after an edge like every other input
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

// File: verif/cpu_assertions.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_assertions import cpu_pkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       inst_req,
    input logic       retire,
    input word_t      debug_wb_pc,
    input logic [3:0] debug_wb_rf_we,
    input reg_addr_t  debug_wb_rf_wnum,
    input word_t      debug_wb_rf_wdata
);

    // architectural state that steps once per retirement
    word_t     model_rf [32];
    word_t     exp_pc;

    word_t     cur_inst;
    word_t     val_j;
    word_t     val_k;
    word_t     val_d;
    word_t     br_offset;
    logic      exp_wr;
    reg_addr_t exp_dest;
    word_t     exp_result;
    word_t     exp_next_pc;

    always_comb begin
        cur_inst    = tb_top.rom[exp_pc[9:2]];
        exp_dest    = cur_inst[4:0];
        val_j       = model_rf[cur_inst[9:5]];
        val_k       = model_rf[cur_inst[14:10]];
        val_d       = model_rf[cur_inst[4:0]];
        br_offset   = {{14{cur_inst[25]}}, cur_inst[25:10], 2'b00};
        exp_wr      = 1'b1;
        exp_result  = '0;
        exp_next_pc = exp_pc + 32'd4;
        case (cur_inst[31:15])
            `OP_ADD_W: exp_result = val_j + val_k;
            `OP_SUB_W: exp_result = val_j - val_k;
            `OP_SLT:   exp_result = ($signed(val_j) < $signed(val_k)) ? 32'd1 : 32'd0;
            `OP_SLTU:  exp_result = (val_j < val_k) ? 32'd1 : 32'd0;
            `OP_AND:   exp_result = val_j & val_k;
            `OP_OR:    exp_result = val_j | val_k;
            `OP_XOR:   exp_result = val_j ^ val_k;
            default: begin
                exp_wr = 1'b0;
                if (cur_inst[31:22] == `OP_ADDI_W) begin
                    exp_wr     = 1'b1;
                    exp_result = val_j + {{20{cur_inst[21]}}, cur_inst[21:10]};
                end else if (cur_inst[31:25] == `OP_LU12I_W) begin
                    exp_wr     = 1'b1;
                    exp_result = {cur_inst[24:5], 12'h000};
                end else if (cur_inst[31:26] == `OP_B) begin
                    exp_next_pc = exp_pc
                                + {{4{cur_inst[9]}}, cur_inst[9:0], cur_inst[25:10], 2'b00};
                end else if (cur_inst[31:26] == `OP_BEQ && val_j == val_d) begin
                    exp_next_pc = exp_pc + br_offset;
                end else if (cur_inst[31:26] == `OP_BNE && val_j != val_d) begin
                    exp_next_pc = exp_pc + br_offset;
                end
            end
        endcase
        // r0 is hardwired to zero
        if (exp_dest == 5'd0) begin
            exp_wr = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exp_pc <= `RESET_PC;
            for (int i = 0; i < 32; i++) begin
                model_rf[i[4:0]] <= '0;
            end
        end else if (retire) begin
            exp_pc <= exp_next_pc;
            if (exp_wr) begin
                model_rf[exp_dest] <= exp_result;
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        reset |=> (inst_req == 1'b0 && debug_wb_rf_we == 4'h0))
    else begin
        $error("Error inst_req %h debug_wb_rf_we %h, expected 0 after a reset cycle",
               $sampled(inst_req), $sampled(debug_wb_rf_we));
        tb_top.error_count = tb_top.error_count + 1;
    end

    a_retire_pc: assert property (@(posedge clk) disable iff (reset)
        retire |-> debug_wb_pc == exp_pc)
    else begin
        $error("Error debug_wb_pc %h expected %h", $sampled(debug_wb_pc), $sampled(exp_pc));
        tb_top.error_count = tb_top.error_count + 1;
    end

    // also catches writes to r0 and writes from empty slots
    a_write_enable: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_we == ((retire && exp_wr) ? 4'hf : 4'h0))
    else begin
        $error("Error debug_wb_rf_we %h expected %h at pc %h",
               $sampled(debug_wb_rf_we),
               ($sampled(retire) && $sampled(exp_wr)) ? 4'hf : 4'h0,
               $sampled(exp_pc));
        tb_top.error_count = tb_top.error_count + 1;
    end

    a_write_data: assert property (@(posedge clk) disable iff (reset)
        retire && exp_wr |-> debug_wb_rf_wnum == exp_dest && debug_wb_rf_wdata == exp_result)
    else begin
        $error("Error debug_wb_rf_wnum %h debug_wb_rf_wdata %h expected %h %h",
               $sampled(debug_wb_rf_wnum), $sampled(debug_wb_rf_wdata),
               $sampled(exp_dest), $sampled(exp_result));
        tb_top.error_count = tb_top.error_count + 1;
    end

endmodule

// File: verif/tb_top.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module tb_top import cpu_pkg::*; ();

    localparam int    PROG_LEN        = 200;
    localparam int    WATCHDOG_CYCLES = PROG_LEN * 4 + 50;
    localparam word_t FINAL_PC        = `RESET_PC + 32'(4 * (PROG_LEN - 1));

    logic       clk;
    logic       reset;
    logic       inst_req;
    word_t      inst_addr;
    word_t      inst_rdata;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_we;
    reg_addr_t  debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    word_t      rom [256];
    int         error_count   = 0;
    int         retired_count = 0;
    int         final_seen    = 0;
    integer     seed          = 68670;

    clk_gen u_clk_gen (
        .clk   (clk),
        .reset (reset)
    );

    cpu_core_top UUT (
        .clk               (clk),
        .reset             (reset),
        .inst_req          (inst_req),
        .inst_addr         (inst_addr),
        .inst_rdata        (inst_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    bind cpu_core_top cpu_assertions u_assertions (
        .clk               (clk),
        .reset             (reset),
        .inst_req          (inst_req),
        .retire            (ex_wb.valid),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    function automatic logic [7:0] rom_index(input word_t addr);
        word_t offset;
        offset = addr - `RESET_PC;
        return offset[9:2];
    endfunction

    task automatic build_program();
        logic [31:0] rnd;
        logic [31:0] imm;
        reg_addr_t   rd;
        reg_addr_t   rj;
        reg_addr_t   rk;
        logic [15:0] offs;
        // unused words hold addi.w r0, r0, <word index>
        for (int i = 0; i < 256; i++) begin
            rom[i[7:0]] = {`OP_ADDI_W, 4'h0, i[7:0], 10'd0};
        end
        // rf has no reset, so r1..r7 get a value first
        for (int i = 1; i < 8; i++) begin
            imm = $random(seed);
            rom[8'(i - 1)] = {`OP_ADDI_W, imm[11:0], 5'd0, i[4:0]};
        end
        for (int i = 7; i < PROG_LEN - 1; i++) begin
            rnd  = $random(seed);
            imm  = $random(seed);
            rd   = {2'b00, rnd[18:16]};
            rj   = {2'b00, rnd[21:19]};
            rk   = {2'b00, rnd[24:22]};
            offs = rnd[5] ? 16'd3 : 16'd2;
            // +8/+12 targets must stay inside the program
            if (rnd[2:0] == 3'd0 && i < PROG_LEN - 3) begin
                case (rnd[4:3])
                    2'd0:    rom[i[7:0]] = {`OP_BEQ, offs, rj, rd};
                    2'd1:    rom[i[7:0]] = {`OP_BNE, offs, rj, rd};
                    default: rom[i[7:0]] = {`OP_B, offs, 10'd0};
                endcase
            end else begin
                case (rnd[15:12])
                    4'd0:    rom[i[7:0]] = {`OP_ADD_W, rk, rj, rd};
                    4'd1:    rom[i[7:0]] = {`OP_SUB_W, rk, rj, rd};
                    4'd2:    rom[i[7:0]] = {`OP_SLT, rk, rj, rd};
                    4'd3:    rom[i[7:0]] = {`OP_SLTU, rk, rj, rd};
                    4'd4:    rom[i[7:0]] = {`OP_AND, rk, rj, rd};
                    4'd5:    rom[i[7:0]] = {`OP_OR, rk, rj, rd};
                    4'd6:    rom[i[7:0]] = {`OP_XOR, rk, rj, rd};
                    4'd13,
                    4'd14,
                    4'd15:   rom[i[7:0]] = {`OP_LU12I_W, imm[31:12], rd};
                    default: rom[i[7:0]] = {`OP_ADDI_W, imm[11:0], rj, rd};
                endcase
            end
        end
        // the program spins here on b 0
        rom[8'(PROG_LEN - 1)] = {`OP_B, 26'd0};
    endtask

    task automatic finish_run(input logic timed_out);
        $display("errors: %0d, retired: %0d", error_count, retired_count);
        if (error_count == 0 && !timed_out) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // instruction memory returning each word one cycle after its request
    initial begin
        logic  pending;
        word_t pending_addr;
        pending      = 1'b0;
        pending_addr = '0;
        inst_rdata   = '0;
        forever begin
            @(posedge clk);
            #1;
            if (pending) begin
                inst_rdata = rom[rom_index(pending_addr)];
            end
            pending      = inst_req;
            pending_addr = inst_addr;
        end
    end

    always @(negedge clk) begin
        if (!reset && UUT.ex_wb.valid) begin
            retired_count++;
            if (debug_wb_pc == FINAL_PC) begin
                final_seen++;
            end
        end
    end

    initial begin
        build_program();
        wait (final_seen >= 2);
        // last retirement still gets checked on this edge
        @(posedge clk);
        #1;
        finish_run(1'b0);
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: self loop at %h not retired twice within %0d cycles",
                 FINAL_PC, WATCHDOG_CYCLES);
        finish_run(1'b1);
    end

endmodule

// File: sim.f
+incdir+design
design/cpu_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/regfile.sv
design/cpu_core_top.sv
verif/clk_gen.sv
verif/cpu_assertions.sv
verif/tb_top.sv

// File: Makefile
TOP = tb_top

.PHONY: run compile clean

run: compile
	@out="$$(./obj_dir/$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f sim.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

clean:
	rm -rf obj_dir
